/* sources.f */
+incdir+hdl
hdl/mem_req_pkg.sv
hdl/resp_fifo.sv
hdl/active_req_tracker.sv
hdl/mem_responder.sv
hdl/tracker_apb_regs.sv
hdl/mem_req_subsys.sv
bench/mem_req_subsys_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := mem_req_subsys_tb
FILELIST := sources.f
LOG      := sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/mem_req_subsys_tb.sv */
`timescale 1ns/1ps
/*
 * Directed tests of the request path through both channels and the APB port.
 * Responses are expected in request order per channel, with no order between channels.
 * The run stops at the first error or when the cycle limit is reached.
 */
`include "mem_req_params.svh"

module mem_req_subsys_tb;

    import mem_req_pkg::*;

    localparam int RD_BURST = 6;
    localparam int RAND_COUNT = 48;
    localparam int CYCLES_PER_REQ = 40;
    // Test 3 sends seven requests and test 4 at most one FIFO depth
    localparam int TOTAL_REQS = RD_BURST + 7 + `RESP_FIFO_DEPTH + RAND_COUNT;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * CYCLES_PER_REQ;

    // One expected read beat
    typedef struct packed {
        logic [15:0] tag;
        logic [1:0]  cl_num;
    } beat_t;

    logic clk = 1'b0;
    logic reset;
    c0_tx_t c0_tx;
    c1_tx_t c1_tx;
    apb_req_t apb_req;
    c0_rx_t c0_rx;
    c1_rx_t c1_rx;
    logic c0_almost_full;
    logic c1_almost_full;
    apb_rsp_t apb_rsp;

    // Expected responses in the order the responder must produce them
    beat_t rd_beats[$];
    wr_entry_t c1_exp[$];

    // Sent counts grow in the stimulus tasks and done counts in the monitors
    int c0_lines_sent = 0;
    int c0_lines_done = 0;
    int c1_lines_sent = 0;
    int c1_lines_done = 0;
    int fences_sent = 0;
    int fences_done = 0;
    int cycle_count = 0;
    logic [31:0] lfsr_state = 32'h626d;

    always #4 clk = ~clk;

    mem_req_subsys mem_req_subsys_inst
    (
        .clk(clk),
        .reset(reset),
        .c0_tx(c0_tx),
        .c1_tx(c1_tx),
        .apb_req(apb_req),
        .c0_rx(c0_rx),
        .c1_rx(c1_rx),
        .c0_almost_full(c0_almost_full),
        .c1_almost_full(c1_almost_full),
        .apb_rsp(apb_rsp)
    );

    task automatic abort(input string msg);
        $display("ERROR: %s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "run stopped");
        end
    endtask

    // Galois LFSR with taps 32,22,2,1, one step per bit taken
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            if (lfsr_state[0])
            begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end
            else
            begin
                lfsr_state = lfsr_state >> 1;
            end
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            abort("run exceeded the cycle limit without finishing");
        end
    end

    // Each read beat must match the oldest expected beat
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && c0_rx.valid === 1'b1)
            begin
                take_read_response();
            end
            if (!reset && c1_rx.valid === 1'b1)
            begin
                take_write_response();
            end
        end
    end

    task automatic take_read_response();
        beat_t exp;
        if (rd_beats.size() == 0)
        begin
            abort("read response arrived with no read line in flight");
        end
        else
        begin
            exp = rd_beats.pop_front();
            check_value("c0_rx.tag", 32'(c0_rx.tag), 32'(exp.tag));
            check_value("c0_rx.cl_num", 32'(c0_rx.cl_num), 32'(exp.cl_num));
            c0_lines_done++;
        end
    endtask

    // A write response covers the oldest writes and never passes a fence
    task automatic take_write_response();
        int n;
        if (c1_exp.size() == 0)
        begin
            abort("write channel response arrived with nothing in flight");
        end
        else if (c1_rx.is_fence)
        begin
            check_value("c1_rx.is_fence at queue head", 32'(c1_exp[0].is_fence), 32'h1);
            check_value("c1_rx.tag", 32'(c1_rx.tag), 32'(c1_exp[0].tag));
            void'(c1_exp.pop_front());
            fences_done++;
        end
        else
        begin
            n = c1_rx.format ? int'(c1_rx.cl_num) + 1 : 1;
            check_value("c1_rx.tag", 32'(c1_rx.tag), 32'(c1_exp[0].tag));
            for (int i = 0; i < n; i++)
            begin
                if (c1_exp.size() == 0)
                begin
                    abort("packed write response covers more writes than were sent");
                end
                else
                begin
                    check_value("c1_rx group member is_fence", 32'(c1_exp[0].is_fence), 32'h0);
                    void'(c1_exp.pop_front());
                end
            end
            c1_lines_done += n;
        end
    endtask

    task automatic send_read(input logic [15:0] req_tag, input logic [1:0] len);
        beat_t beat;
        @(negedge clk);
        while (c0_almost_full)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        c0_tx <= '{valid: 1'b1, tag: req_tag, cl_len: len};
        for (int i = 0; i <= int'(len); i++)
        begin
            beat.tag = req_tag;
            beat.cl_num = 2'(i);
            rd_beats.push_back(beat);
        end
        c0_lines_sent += int'(len) + 1;
        @(posedge clk);
        c0_tx <= '0;
    endtask

    task automatic send_write(input logic [15:0] req_tag, input logic is_fence);
        wr_entry_t entry;
        @(negedge clk);
        while (c1_almost_full)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        c1_tx <= '{valid: 1'b1, is_fence: is_fence, tag: req_tag};
        entry.is_fence = is_fence;
        entry.tag = req_tag;
        c1_exp.push_back(entry);
        if (is_fence)
        begin
            fences_sent++;
        end
        else
        begin
            c1_lines_sent++;
        end
        @(posedge clk);
        c1_tx <= '0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'h1);
        check_value("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'h0);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Data and error are sampled mid-cycle of the access phase
        @(negedge clk);
        check_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'h1);
        data = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic check_reg(input logic [4:0] addr, input string name,
                             input logic [31:0] exp);
        logic [31:0] data;
        logic err;
        apb_read(addr, data, err);
        check_value({name, " pslverr"}, 32'(err), 32'h0);
        check_value(name, data, exp);
    endtask

    // Waits until every expected response of both channels has been seen
    task automatic wait_for_drain();
        @(negedge clk);
        while (rd_beats.size() != 0 || c1_exp.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        check_value("c0_rx.valid", 32'(c0_rx.valid), 32'h0);
        check_value("c1_rx.valid", 32'(c1_rx.valid), 32'h0);
        check_value("c0_almost_full", 32'(c0_almost_full), 32'h0);
        check_value("c1_almost_full", 32'(c1_almost_full), 32'h0);
        check_reg(`REG_STATUS, "REG_STATUS", 32'h0);
        check_reg(`REG_C0_LINES, "REG_C0_LINES", 32'h0);
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'h0);
        check_reg(`REG_FENCES, "REG_FENCES", 32'h0);
        check_reg(`REG_CONTROL, "REG_CONTROL", 32'h0);
    endtask

    task automatic test_paused_reads();
        logic [1:0] len;
        int sum;
        int done_before;
        sum = 0;
        done_before = c0_lines_done;
        apb_write(`REG_CONTROL, 32'h1);
        for (int i = 0; i < RD_BURST; i++)
        begin
            len = 2'(lfsr_take(2));
            sum += int'(len) + 1;
            send_read(16'h1000 + 16'(i), len);
        end
        check_reg(`REG_C0_LINES, "REG_C0_LINES", 32'(sum));
        check_reg(`REG_STATUS, "REG_STATUS", 32'h1);
        check_value("c0 lines answered while paused", 32'(c0_lines_done - done_before), 32'h0);
        apb_write(`REG_CONTROL, 32'h0);
        wait_for_drain();
        check_reg(`REG_C0_LINES, "REG_C0_LINES", 32'h0);
        check_reg(`REG_STATUS, "REG_STATUS", 32'h0);
    endtask

    task automatic test_write_groups();
        apb_write(`REG_CONTROL, 32'h1);
        for (int i = 0; i < 6; i++)
        begin
            send_write(16'h2000 + 16'(i), 1'b0);
        end
        send_write(16'h20ff, 1'b1);
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'd6);
        check_reg(`REG_FENCES, "REG_FENCES", 32'd1);
        apb_write(`REG_CONTROL, 32'h0);
        // The fence can only retire after the six writes ahead of it
        wait_for_drain();
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'h0);
        check_reg(`REG_FENCES, "REG_FENCES", 32'h0);
    endtask

    task automatic test_backpressure();
        int sent;
        sent = 0;
        apb_write(`REG_CONTROL, 32'h1);
        @(negedge clk);
        while (!c1_almost_full)
        begin
            send_write(16'h3000 + 16'(sent), 1'b0);
            sent++;
            @(negedge clk);
        end
        // Almost-full rises once only the slack entries are left free
        check_value("writes sent before c1_almost_full", 32'(sent),
                    32'(`RESP_FIFO_DEPTH - `ALMOST_FULL_SLACK));
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'(sent));
        apb_write(`REG_CONTROL, 32'h0);
        wait_for_drain();
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'h0);
    endtask

    task automatic test_apb_access();
        logic [31:0] data;
        logic err;
        apb_read(5'h14, data, err);
        check_value("apb_rsp.pslverr unmapped", 32'(err), 32'h1);
        apb_write(`REG_CONTROL, 32'h1);
        check_reg(`REG_CONTROL, "REG_CONTROL", 32'h1);
        apb_write(`REG_CONTROL, 32'h0);
        check_reg(`REG_CONTROL, "REG_CONTROL", 32'h0);
    endtask

    task automatic test_random_traffic();
        logic [1:0] kind;
        logic [15:0] tag;
        for (int i = 0; i < RAND_COUNT; i++)
        begin
            kind = 2'(lfsr_take(2));
            tag = 16'(lfsr_take(16));
            if (kind[1] == 1'b0)
            begin
                send_read(tag, 2'(lfsr_take(2)));
            end
            else if (kind == 2'd2)
            begin
                send_write(tag, 1'b0);
            end
            else
            begin
                send_write(tag, 1'(lfsr_take(1)));
            end
        end
        wait_for_drain();
        check_reg(`REG_C0_LINES, "REG_C0_LINES", 32'(c0_lines_sent - c0_lines_done));
        check_reg(`REG_C1_LINES, "REG_C1_LINES", 32'(c1_lines_sent - c1_lines_done));
        check_reg(`REG_FENCES, "REG_FENCES", 32'(fences_sent - fences_done));
        check_reg(`REG_STATUS, "REG_STATUS", 32'h0);
    endtask

    initial
    begin
        reset = 1'b1;
        c0_tx = '0;
        c1_tx = '0;
        apb_req = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_paused_reads();
        test_write_groups();
        test_backpressure();
        test_apb_access();
        test_random_traffic();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* hdl/mem_req_subsys.sv */
`timescale 1ns/1ps
/*
 * Memory request path with responder, request tracker and APB registers.
 * The master must hold off a channel while its almost-full is high.
 */
module mem_req_subsys
(
    input  logic                  clk,
    input  logic                  reset,
    input  mem_req_pkg::c0_tx_t   c0_tx,
    input  mem_req_pkg::c1_tx_t   c1_tx,
    input  mem_req_pkg::apb_req_t apb_req,
    output mem_req_pkg::c0_rx_t   c0_rx,
    output mem_req_pkg::c1_rx_t   c1_rx,
    output logic                  c0_almost_full,
    output logic                  c1_almost_full,
    output mem_req_pkg::apb_rsp_t apb_rsp
);

    import mem_req_pkg::*;

    active_counts_t counts;
    logic pause;

    mem_responder mem_responder_inst
    (
        .clk(clk),
        .reset(reset),
        .c0_tx(c0_tx),
        .c1_tx(c1_tx),
        .pause(pause),
        .c0_rx(c0_rx),
        .c1_rx(c1_rx),
        .c0_almost_full(c0_almost_full),
        .c1_almost_full(c1_almost_full)
    );

    // The tracker watches the same channels that the responder serves
    active_req_tracker active_req_tracker_inst
    (
        .clk(clk),
        .reset(reset),
        .c0_tx(c0_tx),
        .c1_tx(c1_tx),
        .c0_rx(c0_rx),
        .c1_rx(c1_rx),
        .counts(counts)
    );

    tracker_apb_regs tracker_apb_regs_inst
    (
        .clk(clk),
        .reset(reset),
        .apb_req(apb_req),
        .counts(counts),
        .apb_rsp(apb_rsp),
        .pause(pause)
    );

endmodule

/* hdl/tracker_apb_regs.sv */
`timescale 1ns/1ps
/*
 * APB register port of the tracker with no wait states.
 * Only the pause bit of REG_CONTROL is writable.
 * Unmapped offsets answer with pslverr in the access phase.
 */
`include "mem_req_params.svh"

module tracker_apb_regs
(
    input  logic                        clk,
    input  logic                        reset,
    input  mem_req_pkg::apb_req_t       apb_req,
    input  mem_req_pkg::active_counts_t counts,
    output mem_req_pkg::apb_rsp_t       apb_rsp,
    output logic                        pause
);

    import mem_req_pkg::*;

    logic access;
    logic mapped;
    logic [31:0] rd_data;

    // Access phase of a transfer
    assign access = apb_req.psel && apb_req.penable;

    always_comb
    begin
        mapped = 1'b1;
        rd_data = 32'd0;
        case (apb_req.paddr)
            `REG_STATUS:   rd_data = {30'd0, counts.c1_not_empty, counts.c0_not_empty};
            `REG_C0_LINES: rd_data = 32'(counts.c0_lines);
            `REG_C1_LINES: rd_data = 32'(counts.c1_lines);
            `REG_FENCES:   rd_data = 32'(counts.fences);
            `REG_CONTROL:  rd_data = {31'd0, pause};
            default:       mapped = 1'b0;
        endcase
    end

    assign apb_rsp.prdata = (access && !apb_req.pwrite) ? rd_data : 32'd0;
    assign apb_rsp.pready = access;
    assign apb_rsp.pslverr = access && !mapped;

    // Writes to the read-only counters fall through and are dropped
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pause <= 1'b0;
        end
        else if (access && apb_req.pwrite && (apb_req.paddr == `REG_CONTROL))
        begin
            pause <= apb_req.pwdata[0];
        end
    end

endmodule

/* hdl/mem_responder.sv */
`timescale 1ns/1ps
/*
 * Answers read and write requests with tag-only responses.
 * Requests must stop while the matching almost-full is high.
 * Pause halts all responses but requests are still queued.
 */
module mem_responder
(
    input  logic                clk,
    input  logic                reset,
    input  mem_req_pkg::c0_tx_t c0_tx,
    input  mem_req_pkg::c1_tx_t c1_tx,
    input  logic                pause,
    output mem_req_pkg::c0_rx_t c0_rx,
    output mem_req_pkg::c1_rx_t c1_rx,
    output logic                c0_almost_full,
    output logic                c1_almost_full
);

    import mem_req_pkg::*;

    // Largest number of write lines covered by one packed response
    localparam int MAX_GROUP = 4;

    rd_entry_t rd_push_data;
    rd_entry_t rd_head;
    logic rd_empty;
    logic rd_pop;

    wr_entry_t wr_push_data;
    wr_entry_t wr_head;
    logic wr_empty;
    logic wr_pop;

    // Read side state
    logic [1:0] rd_age;
    logic [1:0] rd_beat;
    logic rd_issue;

    // Write grouping state
    logic [2:0] grp_cnt;
    tag_t grp_tag;
    logic grp_add;
    logic grp_emit;
    logic fence_emit;

    // Requests enter their FIFO in the cycle they arrive
    assign rd_push_data = '{tag: c0_tx.tag, cl_len: c0_tx.cl_len};
    assign wr_push_data = '{is_fence: c1_tx.is_fence, tag: c1_tx.tag};

    resp_fifo #(.entry_t(rd_entry_t)) rd_fifo_inst
    (
        .clk(clk),
        .reset(reset),
        .push(c0_tx.valid),
        .push_data(rd_push_data),
        .pop(rd_pop),
        .head(rd_head),
        .empty(rd_empty),
        .almost_full(c0_almost_full)
    );

    resp_fifo #(.entry_t(wr_entry_t)) wr_fifo_inst
    (
        .clk(clk),
        .reset(reset),
        .push(c1_tx.valid),
        .push_data(wr_push_data),
        .pop(wr_pop),
        .head(wr_head),
        .empty(wr_empty),
        .almost_full(c1_almost_full)
    );

    // The head read may only answer once the age stage has filled
    assign rd_issue = !pause && !rd_empty && rd_age[1];

    // The last beat of the head entry retires it
    assign rd_pop = rd_issue && (rd_beat == rd_head.cl_len);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_age <= 2'b00;
            rd_beat <= 2'd0;
            c0_rx.valid <= 1'b0;
        end
        else
        begin
            // Age restarts whenever the read FIFO drains
            rd_age <= rd_empty ? 2'b00 : {rd_age[0], 1'b1};
            c0_rx.valid <= rd_issue;
            if (rd_pop)
            begin
                rd_beat <= 2'd0;
            end
            else if (rd_issue)
            begin
                rd_beat <= rd_beat + 2'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        c0_rx.tag <= rd_head.tag;
        c0_rx.cl_num <= rd_beat;
    end

    // Writes at the head join the open group until a fence or a full group
    assign grp_add = !pause && !wr_empty && !wr_head.is_fence &&
                     (grp_cnt != 3'(MAX_GROUP));

    // The group is answered when nothing more can join it
    assign grp_emit = !pause && (grp_cnt != 3'd0) &&
                      (wr_empty || wr_head.is_fence || (grp_cnt == 3'(MAX_GROUP)));

    // A fence waits until every earlier write group has been answered
    assign fence_emit = !pause && !wr_empty && wr_head.is_fence && (grp_cnt == 3'd0);

    assign wr_pop = grp_add || fence_emit;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grp_cnt <= 3'd0;
            c1_rx.valid <= 1'b0;
        end
        else
        begin
            if (grp_emit)
            begin
                grp_cnt <= 3'd0;
            end
            else if (grp_add)
            begin
                grp_cnt <= grp_cnt + 3'd1;
            end
            c1_rx.valid <= grp_emit || fence_emit;
        end
    end

    always_ff @(posedge clk)
    begin
        // The first write of a group names the packed response
        if (grp_add && (grp_cnt == 3'd0))
        begin
            grp_tag <= wr_head.tag;
        end
        c1_rx.is_fence <= fence_emit;
        c1_rx.format <= grp_emit && (grp_cnt > 3'd1);
        c1_rx.cl_num <= fence_emit ? 2'd0 : 2'(grp_cnt - 3'd1);
        c1_rx.tag <= fence_emit ? wr_head.tag : grp_tag;
    end

endmodule

/* hdl/active_req_tracker.sv */
`timescale 1ns/1ps
/*
 * Watches both request channels and counts lines in flight and open fences.
 * Counts are taken at the channel edge, so they may exceed the design limit.
 * Results appear one clock after the request or response is seen.
 */
module active_req_tracker
(
    input  logic                        clk,
    input  logic                        reset,
    input  mem_req_pkg::c0_tx_t         c0_tx,
    input  mem_req_pkg::c1_tx_t         c1_tx,
    input  mem_req_pkg::c0_rx_t         c0_rx,
    input  mem_req_pkg::c1_rx_t         c1_rx,
    output mem_req_pkg::active_counts_t counts
);

    import mem_req_pkg::*;

    // Per-cycle changes, wide enough for a four-line request or packed response
    logic [2:0] c0_incr;
    logic c0_decr;
    logic c1_incr;
    logic [2:0] c1_decr;
    logic fence_req;
    logic fence_rsp;

    always_comb
    begin
        // A read request adds cl_len plus one lines
        if (c0_tx.valid)
        begin
            c0_incr = 3'd1 + 3'(c0_tx.cl_len);
        end
        else
        begin
            c0_incr = 3'd0;
        end
        c0_decr = c0_rx.valid;

        c1_incr = c1_tx.valid && !c1_tx.is_fence;
        fence_req = c1_tx.valid && c1_tx.is_fence;
        fence_rsp = c1_rx.valid && c1_rx.is_fence;

        if (c1_rx.valid && !c1_rx.is_fence)
        begin
            if (c1_rx.format)
            begin
                // A packed response retires several lines at once
                c1_decr = 3'd1 + 3'(c1_rx.cl_num);
            end
            else
            begin
                c1_decr = 3'd1;
            end
        end
        else
        begin
            c1_decr = 3'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        // Not-empty also covers a request that arrives in this cycle
        counts.c0_not_empty <= c0_tx.valid || (|counts.c0_lines);
        counts.c1_not_empty <= c1_incr || (|counts.c1_lines);

        counts.c0_lines <= counts.c0_lines + line_cnt_t'(c0_incr) - line_cnt_t'(c0_decr);
        counts.c1_lines <= counts.c1_lines + line_cnt_t'(c1_incr) - line_cnt_t'(c1_decr);

        if (reset)
        begin
            counts.c0_not_empty <= 1'b0;
            counts.c1_not_empty <= 1'b0;
            counts.c0_lines <= '0;
            counts.c1_lines <= '0;
        end
    end

    // A fence request and a fence response in one cycle leave the count alone
    always_ff @(posedge clk)
    begin
        if (fence_req && !fence_rsp)
        begin
            counts.fences <= counts.fences + fence_cnt_t'(1);
        end
        else if (!fence_req && fence_rsp)
        begin
            counts.fences <= counts.fences - fence_cnt_t'(1);
        end

        if (reset)
        begin
            counts.fences <= '0;
        end
    end

endmodule

/* hdl/resp_fifo.sv */
`timescale 1ns/1ps
/*
 * Circular buffer of `RESP_FIFO_DEPTH entries of any packed type.
 * Almost-full is registered, so a writer sees it one cycle late.
 * A push into a full FIFO or a pop from an empty one is dropped.
 */
`include "mem_req_params.svh"

module resp_fifo
#(
    parameter type entry_t = logic [15:0]
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   empty,
    output logic   almost_full
);

    localparam int DEPTH = `RESP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic [PTR_W:0] count_next;
    logic do_push;
    logic do_pop;

    assign do_push = push && (count != (PTR_W+1)'(DEPTH));
    assign do_pop = pop && !empty;
    assign empty = (count == '0);
    assign head = mem[rd_ptr];

    assign count_next = count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);

    // Storage has no reset, only the pointers and level do
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_ptr + PTR_W'(do_push);
            rd_ptr <= rd_ptr + PTR_W'(do_pop);
            count <= count_next;
            // Raised with ALMOST_FULL_SLACK entries free to absorb the flag delay
            almost_full <= (count_next >= (PTR_W+1)'(DEPTH - `ALMOST_FULL_SLACK));
        end
    end

endmodule

/* hdl/mem_req_pkg.sv */
/*
 * Channel records, FIFO payloads and APB records of the request path.
 * Payloads carry tags only. No memory data is modelled.
 */
package mem_req_pkg;

    `include "mem_req_params.svh"

    typedef logic [15:0] tag_t;

    // Counters are one bit wider than the limits require
    typedef logic [$clog2(`MAX_ACTIVE_LINES):0] line_cnt_t;
    typedef logic [$clog2(`MAX_ACTIVE_FENCES):0] fence_cnt_t;

    // Read request of one to four lines, cl_len is the line count minus one
    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic [1:0] cl_len;
    } c0_tx_t;

    // One read response per line
    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic [1:0] cl_num;
    } c0_rx_t;

    typedef struct packed {
        logic valid;
        logic is_fence;
        tag_t tag;
    } c1_tx_t;

    // With format set the response is packed and cl_num is the covered line count minus one
    typedef struct packed {
        logic       valid;
        logic       is_fence;
        logic       format;
        logic [1:0] cl_num;
        tag_t       tag;
    } c1_rx_t;

    typedef struct packed {
        tag_t       tag;
        logic [1:0] cl_len;
    } rd_entry_t;

    typedef struct packed {
        logic is_fence;
        tag_t tag;
    } wr_entry_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic       c0_not_empty;
        logic       c1_not_empty;
        line_cnt_t  c0_lines;
        line_cnt_t  c1_lines;
        fence_cnt_t fences;
    } active_counts_t;

endpackage

/* hdl/mem_req_params.svh */
/*
 * Limits, FIFO sizing and register offsets for the memory request path.
 * The line counters hold one more bit than MAX_ACTIVE_LINES needs.
 * Register offsets are byte addresses on a 5-bit APB address.
 */
`ifndef MEM_REQ_PARAMS_SVH
`define MEM_REQ_PARAMS_SVH

// Design limits of work in flight
`define MAX_ACTIVE_LINES 64
`define MAX_ACTIVE_FENCES 8

// Response FIFOs raise almost-full with this many entries still free
`define RESP_FIFO_DEPTH 16
`define ALMOST_FULL_SLACK 4

// APB register map of the tracker
`define REG_STATUS 5'h00
`define REG_C0_LINES 5'h04
`define REG_C1_LINES 5'h08
`define REG_FENCES 5'h0C
`define REG_CONTROL 5'h10

`endif
